//--- core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// architectural register count.
`define RegNum 32

// width of a data word.
`define DataWidth 32

// width of a reorder-buffer tag.
`define NickWidth 3

// reorder-buffer entries, named by nicks 1 to 7.
`define RobDepth 7

`endif

//--- isaPkg.sv
`include "core_consts.svh"

package isaPkg;

    // data and instruction word.
    typedef logic [`DataWidth-1:0] wordT;

    // architectural register name.
    typedef logic [$clog2(`RegNum)-1:0] regNameT;

    // alu operations of the supported subset.
    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluSlt   = 3'd5,
        aluPassB = 3'd6
    } aluOpT;

    // rv32i opcodes used by the decoder.
    localparam logic [6:0] opcOp    = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLui   = 7'b0110111;

endpackage

//--- robPkg.sv
`include "core_consts.svh"

package robPkg;

    // tag of the reorder-buffer entry that produces a value.
    typedef logic [`NickWidth-1:0] nickT;

    // value is committed in the register file.
    localparam nickT noNick = '0;

endpackage

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic            clk,
    input  logic            rst,
    input  logic            instValid,
    input  isaPkg::wordT    instWord,
    output logic            decValid,
    output isaPkg::regNameT decRd,
    output isaPkg::regNameT decRs1,
    output isaPkg::regNameT decRs2,
    output isaPkg::aluOpT   decOp,
    output isaPkg::wordT    decImm,
    output logic            decUseImm
);

    logic            supported;
    isaPkg::aluOpT   op;
    isaPkg::wordT    imm;
    logic            useImm;
    isaPkg::regNameT rs1;
    isaPkg::regNameT rs2;

    always_comb begin
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        opcode    = instWord[6:0];
        funct3    = instWord[14:12];
        funct7    = instWord[31:25];
        supported = 1'b0;
        op        = isaPkg::aluAdd;
        useImm    = 1'b0;
        imm       = {{20{instWord[31]}}, instWord[31:20]};
        rs1       = instWord[19:15];
        rs2       = instWord[24:20];
        case (opcode)
            isaPkg::opcOp: begin
                supported = (funct7 == 7'b0000000) &&
                            (funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111});
                case (funct3)
                    3'b000: op = isaPkg::aluAdd;
                    3'b010: op = isaPkg::aluSlt;
                    3'b100: op = isaPkg::aluXor;
                    3'b110: op = isaPkg::aluOr;
                    default: op = isaPkg::aluAnd;
                endcase
                // sub is the only alternate funct7 kept.
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    supported = 1'b1;
                    op        = isaPkg::aluSub;
                end
            end
            isaPkg::opcOpImm: begin
                supported = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
                useImm    = 1'b1;
                rs2       = '0;
                case (funct3)
                    3'b000: op = isaPkg::aluAdd;
                    3'b100: op = isaPkg::aluXor;
                    3'b110: op = isaPkg::aluOr;
                    default: op = isaPkg::aluAnd;
                endcase
            end
            isaPkg::opcLui: begin
                supported = 1'b1;
                useImm    = 1'b1;
                op        = isaPkg::aluPassB;
                imm       = {instWord[31:12], 12'b0};
                rs1       = '0;
                rs2       = '0;
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instValid && supported;
        end
        decRd     <= instWord[11:7];
        decRs1    <= rs1;
        decRs2    <= rs2;
        decOp     <= op;
        decImm    <= imm;
        decUseImm <= useImm;
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  logic            decValid,
    input  isaPkg::regNameT decRd,
    input  isaPkg::regNameT decRs1,
    input  isaPkg::regNameT decRs2,
    input  robPkg::nickT    allocNick,
    output isaPkg::wordT    rs1Data,
    output isaPkg::wordT    rs2Data,
    output robPkg::nickT    rs1Nick,
    output robPkg::nickT    rs2Nick,
    input  logic            commitValid,
    input  isaPkg::regNameT commitReg,
    input  robPkg::nickT    commitNick,
    input  isaPkg::wordT    commitData
);

    isaPkg::wordT regData [`RegNum];
    robPkg::nickT regNick [`RegNum];

    // x0 reads as zero and is never renamed.
    assign rs1Data = (decRs1 == '0) ? '0 : regData[decRs1];
    assign rs2Data = (decRs2 == '0) ? '0 : regData[decRs2];
    assign rs1Nick = (decRs1 == '0) ? robPkg::noNick : regNick[decRs1];
    assign rs2Nick = (decRs2 == '0) ? robPkg::noNick : regNick[decRs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RegNum; i++) begin
                regData[i] <= '0;
                regNick[i] <= robPkg::noNick;
            end
        end else begin
            if (commitValid && commitReg != '0) begin
                regData[commitReg] <= commitData;
                // a younger rename keeps its nick.
                if (regNick[commitReg] == commitNick) begin
                    regNick[commitReg] <= robPkg::noNick;
                end
            end
            // rename comes last so it wins over a same-cycle commit.
            if (decValid && decRd != '0) begin
                regNick[decRd] <= allocNick;
            end
        end
    end

endmodule

//--- aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          inValid,
    input  robPkg::nickT  inNick,
    input  isaPkg::wordT  opA,
    input  isaPkg::wordT  opB,
    input  isaPkg::aluOpT op,
    output logic          aluValid,
    output robPkg::nickT  aluNick,
    output isaPkg::wordT  aluResult
);

    isaPkg::wordT result;

    always_comb begin
        case (op)
            isaPkg::aluAdd:   result = opA + opB;
            isaPkg::aluSub:   result = opA - opB;
            isaPkg::aluAnd:   result = opA & opB;
            isaPkg::aluOr:    result = opA | opB;
            isaPkg::aluXor:   result = opA ^ opB;
            // signed compare.
            isaPkg::aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
            isaPkg::aluPassB: result = opB;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluValid <= 1'b0;
        end else begin
            aluValid <= inValid;
        end
        aluNick   <= inNick;
        aluResult <= result;
    end

endmodule

//--- reorderBuffer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reorderBuffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            decValid,
    input  isaPkg::regNameT decRd,
    input  logic            decUseImm,
    input  isaPkg::wordT    decImm,
    input  isaPkg::wordT    rs1Data,
    input  isaPkg::wordT    rs2Data,
    input  robPkg::nickT    rs1Nick,
    input  robPkg::nickT    rs2Nick,
    output isaPkg::wordT    opA,
    output isaPkg::wordT    opB,
    output robPkg::nickT    allocNick,
    input  logic            aluValid,
    input  robPkg::nickT    aluNick,
    input  isaPkg::wordT    aluResult,
    input  logic            commitRdy,
    output logic            commitValid,
    output isaPkg::regNameT commitReg,
    output robPkg::nickT    commitNick,
    output isaPkg::wordT    commitData,
    output logic            instReady
);

    isaPkg::regNameT entryRd   [1:`RobDepth];
    isaPkg::wordT    entryData [1:`RobDepth];
    logic            entryDone [1:`RobDepth];

    robPkg::nickT         head;
    robPkg::nickT         tail;
    logic [`NickWidth:0]  freeCount;
    logic                 canCommit;

    isaPkg::wordT robRs1Data;
    isaPkg::wordT robRs2Data;
    logic         robRs1Hit;
    logic         robRs2Hit;

    function automatic robPkg::nickT nextPtr(input robPkg::nickT ptr);
        return (ptr == robPkg::nickT'(`RobDepth)) ? robPkg::nickT'(1) : ptr + 1'b1;
    endfunction

    // hit flag on top of the forwarded value.
    function automatic logic [`DataWidth:0] lookup(input robPkg::nickT nick);
        logic [`DataWidth:0] res;
        res = '0;
        if (nick != robPkg::noNick) begin
            if (aluValid && aluNick == nick) begin
                res = {1'b1, aluResult};
            end else if (entryDone[nick]) begin
                res = {1'b1, entryData[nick]};
            end
        end
        return res;
    endfunction

    always_comb begin
        {robRs1Hit, robRs1Data} = lookup(rs1Nick);
        {robRs2Hit, robRs2Data} = lookup(rs2Nick);
    end

    assign opA = (rs1Nick == robPkg::noNick) ? rs1Data : robRs1Data;
    assign opB = decUseImm ? decImm :
                 (rs2Nick == robPkg::noNick) ? rs2Data : robRs2Data;

    assign allocNick = tail;
    assign instReady = freeCount >= 3;

    // done flags outlive commit until the register file write lands.
    assign canCommit = commitRdy && (freeCount != `RobDepth) && entryDone[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= robPkg::nickT'(1);
            tail        <= robPkg::nickT'(1);
            freeCount   <= `RobDepth;
            commitValid <= 1'b0;
            for (int i = 1; i <= `RobDepth; i++) begin
                entryDone[i] <= 1'b0;
            end
        end else begin
            if (aluValid) begin
                entryDone[aluNick] <= 1'b1;
            end
            if (decValid) begin
                entryDone[tail] <= 1'b0;
                tail            <= nextPtr(tail);
            end
            if (canCommit) begin
                head <= nextPtr(head);
            end
            freeCount   <= freeCount - decValid + canCommit;
            commitValid <= canCommit;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            entryRd[tail] <= decRd;
        end
        if (aluValid) begin
            entryData[aluNick] <= aluResult;
        end
        commitReg  <= entryRd[head];
        commitNick <= head;
        commitData <= entryData[head];
    end

endmodule

//--- renameCore.sv
`timescale 1ns/1ps

module renameCore (
    input  logic            clk,
    input  logic            rst,
    input  logic            instValid,
    input  isaPkg::wordT    instWord,
    input  logic            commitRdy,
    output logic            instReady,
    output logic            commitValid,
    output isaPkg::regNameT commitReg,
    output isaPkg::wordT    commitData
);

    logic            decValid;
    isaPkg::regNameT decRd;
    isaPkg::regNameT decRs1;
    isaPkg::regNameT decRs2;
    isaPkg::aluOpT   decOp;
    isaPkg::wordT    decImm;
    logic            decUseImm;

    isaPkg::wordT    rs1Data;
    isaPkg::wordT    rs2Data;
    robPkg::nickT    rs1Nick;
    robPkg::nickT    rs2Nick;

    isaPkg::wordT    opA;
    isaPkg::wordT    opB;
    robPkg::nickT    allocNick;

    logic            aluValid;
    robPkg::nickT    aluNick;
    isaPkg::wordT    aluResult;

    robPkg::nickT    commitNick;

    instDecoder u_instDecoder (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instWord  (instWord),
        .decValid  (decValid),
        .decRd     (decRd),
        .decRs1    (decRs1),
        .decRs2    (decRs2),
        .decOp     (decOp),
        .decImm    (decImm),
        .decUseImm (decUseImm)
    );

    regFile u_regFile (
        .clk         (clk),
        .rst         (rst),
        .decValid    (decValid),
        .decRd       (decRd),
        .decRs1      (decRs1),
        .decRs2      (decRs2),
        .allocNick   (allocNick),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .rs1Nick     (rs1Nick),
        .rs2Nick     (rs2Nick),
        .commitValid (commitValid),
        .commitReg   (commitReg),
        .commitNick  (commitNick),
        .commitData  (commitData)
    );

    aluUnit u_aluUnit (
        .clk       (clk),
        .rst       (rst),
        .inValid   (decValid),
        .inNick    (allocNick),
        .opA       (opA),
        .opB       (opB),
        .op        (decOp),
        .aluValid  (aluValid),
        .aluNick   (aluNick),
        .aluResult (aluResult)
    );

    reorderBuffer u_reorderBuffer (
        .clk         (clk),
        .rst         (rst),
        .decValid    (decValid),
        .decRd       (decRd),
        .decUseImm   (decUseImm),
        .decImm      (decImm),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .rs1Nick     (rs1Nick),
        .rs2Nick     (rs2Nick),
        .opA         (opA),
        .opB         (opB),
        .allocNick   (allocNick),
        .aluValid    (aluValid),
        .aluNick     (aluNick),
        .aluResult   (aluResult),
        .commitRdy   (commitRdy),
        .commitValid (commitValid),
        .commitReg   (commitReg),
        .commitNick  (commitNick),
        .commitData  (commitData),
        .instReady   (instReady)
    );

endmodule

//--- renameCore_props.sv
`timescale 1ns/1ps

module renameCoreProps (
    input logic         clk,
    input logic         rst,
    input logic         instValid,
    input logic         instReady,
    input logic         commitRdy,
    input logic         commitValid,
    input logic         decValid,
    input robPkg::nickT rs1Nick,
    input robPkg::nickT rs2Nick,
    input logic         robRs1Hit,
    input logic         robRs2Hit
);

    // nothing retires right after reset.
    quietAfterReset: assert property (@(posedge clk) rst |=> !commitValid)
        else $error("commitValid high in the cycle after reset");

    commitNeedsRdy: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> $past(commitRdy))
        else $error("commit without commitRdy in the cycle before");

    noInstWhenFull: assert property (@(posedge clk) disable iff (rst)
        instValid |-> instReady)
        else $error("instValid while instReady is low");

    // with a one-cycle ALU every renamed source is already present.
    rs1Present: assert property (@(posedge clk) disable iff (rst)
        (decValid && rs1Nick != robPkg::noNick) |-> robRs1Hit)
        else $error("first source still in flight at dispatch");

    rs2Present: assert property (@(posedge clk) disable iff (rst)
        (decValid && rs2Nick != robPkg::noNick) |-> robRs2Hit)
        else $error("second source still in flight at dispatch");

endmodule

bind renameCore renameCoreProps u_renameCoreProps (
    .clk         (clk),
    .rst         (rst),
    .instValid   (instValid),
    .instReady   (instReady),
    .commitRdy   (commitRdy),
    .commitValid (commitValid),
    .decValid    (decValid),
    .rs1Nick     (rs1Nick),
    .rs2Nick     (rs2Nick),
    .robRs1Hit   (u_reorderBuffer.robRs1Hit),
    .robRs2Hit   (u_reorderBuffer.robRs2Hit)
);

//--- renameCoreTb.sv
`timescale 1ns/1ps

module renameCoreTb;

    localparam int clkPeriod = 4;
    localparam int numInst = 70;
    localparam int randCount = 40;

    // local operation codes for the stimulus.
    localparam int opAdd = 0;
    localparam int opSub = 1;
    localparam int opAnd = 2;
    localparam int opOr = 3;
    localparam int opXor = 4;
    localparam int opSlt = 5;
    localparam int opAddi = 6;
    localparam int opAndi = 7;
    localparam int opOri = 8;
    localparam int opXori = 9;
    localparam int opLui = 10;

    logic        clk;
    logic        rst;
    logic        instValid;
    logic [31:0] instWord;
    logic        commitRdy;
    logic        instReady;
    logic        commitValid;
    logic [4:0]  commitReg;
    logic [31:0] commitData;

    logic [31:0] goldRegs [32];
    logic [4:0]  expRegQ [$];
    logic [31:0] expDataQ [$];
    string       expNameQ [$];
    int          commitCount;
    integer      seed;

    renameCore u_renameCore (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .commitRdy   (commitRdy),
        .instReady   (instReady),
        .commitValid (commitValid),
        .commitReg   (commitReg),
        .commitData  (commitData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] encode(input int op, input int rd, input int rs1,
                                           input int rs2, input int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [11:0] i12;
        d   = rd[4:0];
        s1  = rs1[4:0];
        s2  = rs2[4:0];
        i12 = imm[11:0];
        case (op)
            opAdd:  return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            opSub:  return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            opAnd:  return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            opOr:   return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            opXor:  return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
            opSlt:  return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
            opAddi: return {i12, s1, 3'b000, d, 7'b0010011};
            opAndi: return {i12, s1, 3'b111, d, 7'b0010011};
            opOri:  return {i12, s1, 3'b110, d, 7'b0010011};
            opXori: return {i12, s1, 3'b100, d, 7'b0010011};
            default: return {imm[19:0], d, 7'b0110111};
        endcase
    endfunction

    // reference result from the RV32I definitions.
    function automatic logic [31:0] expected(input int op, input logic [31:0] a,
                                             input logic [31:0] b, input int imm);
        logic [31:0] sext;
        sext = {{20{imm[11]}}, imm[11:0]};
        case (op)
            opAdd:  return a + b;
            opSub:  return a - b;
            opAnd:  return a & b;
            opOr:   return a | b;
            opXor:  return a ^ b;
            opSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opAddi: return a + sext;
            opAndi: return a & sext;
            opOri:  return a | sext;
            opXori: return a ^ sext;
            default: return {imm[19:0], 12'b0};
        endcase
    endfunction

    task automatic sendWord(input logic [31:0] word);
        while (!instReady) begin
            @(negedge clk);
        end
        instValid = 1'b1;
        instWord  = word;
        @(negedge clk);
        instValid = 1'b0;
    endtask

    task automatic issueOp(input int op, input int rd, input int rs1, input int rs2,
                           input int imm, input string name);
        logic [31:0] res;
        res = expected(op, goldRegs[rs1], goldRegs[rs2], imm);
        if (rd != 0) begin
            goldRegs[rd] = res;
        end
        expRegQ.push_back(rd[4:0]);
        expDataQ.push_back(res);
        expNameQ.push_back(name);
        sendWord(encode(op, rd, rs1, rs2, imm));
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expRegQ.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && commitValid) begin
            commitCount++;
            assert (expRegQ.size() != 0) else begin
                $display("commit seen with no instruction outstanding");
                $display("Errors found");
                $fatal(1);
            end
            assert (commitReg == expRegQ[0] && commitData == expDataQ[0]) else begin
                $display("CHECK FAILED %s expected x%0d=%h actual x%0d=%h", expNameQ[0],
                         expRegQ[0], expDataQ[0], commitReg, commitData);
                $display("Errors found");
                $fatal(1);
            end
            void'(expRegQ.pop_front());
            void'(expDataQ.pop_front());
            void'(expNameQ.pop_front());
        end
    end

    // watchdog sized from the instruction count.
    initial begin
        #(numInst * 20 * clkPeriod);
        $display("timeout, the run did not finish in time");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        int held;
        clk         = 1'b0;
        rst         = 1'b1;
        instValid   = 1'b0;
        instWord    = '0;
        commitRdy   = 1'b1;
        commitCount = 0;
        seed        = 11065;
        for (int i = 0; i < 32; i++) begin
            goldRegs[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            assert (!commitValid && instReady) else begin
                $display("CHECK FAILED reset expected idle=1 actual commitValid=%b instReady=%b",
                         commitValid, instReady);
                $display("Errors found");
                $fatal(1);
            end
        end

        issueOp(opAddi, 1, 0, 0, 5, "independent");
        issueOp(opAddi, 2, 0, 0, -3, "independent");
        issueOp(opOri, 3, 0, 0, 'h0f0, "independent");
        issueOp(opXori, 4, 0, 0, 'h7ff, "independent");
        issueOp(opLui, 5, 0, 0, 'h12345, "independent");
        issueOp(opAndi, 6, 0, 0, -1, "independent");
        waitDrain();

        issueOp(opAddi, 1, 1, 0, 1, "chain");
        issueOp(opAdd, 2, 1, 1, 0, "chain");
        issueOp(opSub, 3, 2, 5, 0, "chain");
        issueOp(opAnd, 4, 3, 2, 0, "chain");
        issueOp(opOr, 5, 4, 3, 0, "chain");
        issueOp(opXor, 6, 5, 4, 0, "chain");
        issueOp(opSlt, 7, 6, 5, 0, "chain");
        waitDrain();

        commitRdy = 1'b0;
        issueOp(opAddi, 4, 0, 0, 10, "waw");
        issueOp(opAddi, 4, 0, 0, 20, "waw");
        issueOp(opAdd, 5, 4, 0, 0, "waw");
        repeat (4) @(negedge clk);
        // retire only the older write of x4.
        commitRdy = 1'b1;
        @(negedge clk);
        commitRdy = 1'b0;
        repeat (2) @(negedge clk);
        // x4 still carries the younger nick here.
        issueOp(opAdd, 6, 4, 4, 0, "waw");
        commitRdy = 1'b1;
        waitDrain();
        issueOp(opAdd, 7, 4, 0, 0, "waw");
        waitDrain();

        commitRdy = 1'b0;
        held = commitCount;
        for (int i = 0; i < 5; i++) begin
            issueOp(opAddi, i + 1, i, 0, i + 7, "backpressure");
        end
        repeat (12) @(negedge clk);
        assert (!instReady && commitCount == held) else begin
            $display("CHECK FAILED backpressure expected ready=0 commits=%0d actual %b %0d",
                     held, instReady, commitCount);
            $display("Errors found");
            $fatal(1);
        end
        commitRdy = 1'b1;
        waitDrain();

        // store and mul encodings are outside the subset.
        sendWord(32'h0000_2023);
        sendWord(32'h0220_80b3);
        issueOp(opAddi, 0, 0, 0, 99, "x0");
        issueOp(opAdd, 1, 0, 0, 0, "x0");
        waitDrain();

        for (int i = 0; i < randCount; i++) begin
            // keep commits going while the buffer is nearly full.
            commitRdy = (($random(seed) & 3) != 0) || !instReady;
            issueOp($unsigned($random(seed)) % 11, $unsigned($random(seed)) % 8,
                    $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
                    $random(seed), "random");
            commitRdy = 1'b1;
        end
        waitDrain();
        repeat (10) @(negedge clk);

        if (expRegQ.size() != 0) begin
            $display("instructions were never committed");
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+.
isaPkg.sv
robPkg.sv
instDecoder.sv
regFile.sv
aluUnit.sv
reorderBuffer.sv
renameCore.sv
renameCore_props.sv
renameCoreTb.sv

//--- run.sh
#!/bin/bash
# Build and run the renameCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module renameCoreTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
